// ==== garbage_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module garbage_queue #(
    parameter int COLS = 10
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start,
    input  logic                    garbage_valid,
    input  tetris_pkg::line_count_t garbage_lines,
    input  logic                    clear_valid,
    input  tetris_pkg::line_count_t clear_attack,
    input  logic                    lock_valid,
    input  logic                    settled,
    output tetris_pkg::line_count_t pending_garbage,
    output logic                    attack_valid,
    output tetris_pkg::line_count_t attack_lines,
    output logic                    push_valid,
    output tetris_pkg::col_idx_t    hole_col,
    output logic                    busy
);

    typedef enum logic {
        Q_IDLE,
        Q_ARMED
    } q_state_t;

    q_state_t                state;
    q_state_t                state_next;
    logic [7:0]              lfsr;
    tetris_pkg::line_count_t pending_added;
    tetris_pkg::line_count_t pending_next;
    tetris_pkg::line_count_t remainder;
    logic                    push_due;

    assign push_due   = (state == Q_ARMED) && (pending_garbage != '0);
    // hold pushes back while a clear is still cancelling
    assign push_valid = push_due && settled && !clear_valid;
    assign busy       = !settled || clear_valid || push_due;
    assign hole_col   = tetris_pkg::col_idx_t'(lfsr % COLS);

    // incoming garbage lands before the cancel
    always_comb begin
        pending_added = pending_garbage;
        if (garbage_valid) begin
            pending_added = pending_garbage + garbage_lines;
        end
        pending_next = pending_added;
        remainder    = '0;
        if (clear_valid) begin
            if (clear_attack >= pending_added) begin
                remainder    = clear_attack - pending_added;
                pending_next = '0;
            end else begin
                pending_next = pending_added - clear_attack;
            end
        end else if (push_valid) begin
            pending_next = pending_added - 10'd1;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            Q_IDLE:  if (lock_valid) state_next = Q_ARMED;
            Q_ARMED: if (!lock_valid && pending_garbage == '0) state_next = Q_IDLE;
            default: state_next = Q_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state           <= Q_IDLE;
            pending_garbage <= '0;
            attack_valid    <= 1'b0;
            attack_lines    <= '0;
            lfsr            <= tetris_pkg::GARBAGE_LFSR_SEED;
        end else if (start) begin
            state           <= Q_IDLE;
            pending_garbage <= '0;
            attack_valid    <= 1'b0;
            attack_lines    <= '0;
        end else begin
            state           <= state_next;
            pending_garbage <= pending_next;
            attack_valid    <= clear_valid && (remainder != '0);
            attack_lines    <= remainder;
            if (push_valid) begin
                lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
            end
        end
    end

    // no back-pressure, the caller waits for busy to drop
    a_no_lock_busy: assert property (@(posedge clk) disable iff (!rst_n)
        lock_valid |-> !busy);

endmodule

`default_nettype wire

// ==== line_scanner.sv ====
`timescale 1ns/1ps
`default_nettype none

module line_scanner #(
    parameter int ROWS = 20,
    parameter int COLS = 10
) (
    input  tetris_pkg::tile_t [ROWS-1:0][COLS-1:0] cells,
    output logic [ROWS-1:0]                        full_rows,
    output logic [ROWS-1:0]                        empty_rows,
    output logic                                   settled
);

    always_comb begin
        for (int r = 0; r < ROWS; r++) begin
            full_rows[r]  = 1'b1;
            empty_rows[r] = 1'b1;
            for (int c = 0; c < COLS; c++) begin
                if (cells[r][c] == tetris_pkg::BLANK) begin
                    full_rows[r] = 1'b0;
                end else begin
                    empty_rows[r] = 1'b0;
                end
            end
        end
    end

    // a full row waiting to be cleared also counts as unsettled,
    // so nothing can push or lock on top of it
    always_comb begin
        logic above_filled;
        above_filled = 1'b0;
        settled      = ~|full_rows;
        for (int r = 0; r < ROWS; r++) begin
            if (empty_rows[r] && above_filled) begin
                settled = 1'b0;
            end
            if (!empty_rows[r]) begin
                above_filled = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== line_tally.sv ====
`timescale 1ns/1ps
`default_nettype none

module line_tally #(
    parameter int ROWS = 20
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start,
    input  logic [ROWS-1:0]         full_rows,
    output tetris_pkg::line_count_t lines_cleared,
    output logic                    clear_valid,
    output tetris_pkg::line_count_t clear_attack
);

    tetris_pkg::line_count_t row_count;
    tetris_pkg::line_count_t attack_lookup;

    always_comb begin
        row_count = '0;
        for (int r = 0; r < ROWS; r++) begin
            row_count = row_count + tetris_pkg::line_count_t'(full_rows[r]);
        end
    end

    always_comb begin
        case (row_count)
            10'd1:   attack_lookup = tetris_pkg::ATTACK_SINGLE;
            10'd2:   attack_lookup = tetris_pkg::ATTACK_DOUBLE;
            10'd3:   attack_lookup = tetris_pkg::ATTACK_TRIPLE;
            10'd4:   attack_lookup = tetris_pkg::ATTACK_TETRIS;
            default: attack_lookup = '0;
        endcase
    end

    // full rows are blanked on the same edge, so each clear is seen once
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lines_cleared <= '0;
            clear_valid   <= 1'b0;
            clear_attack  <= '0;
        end else if (start) begin
            lines_cleared <= '0;
            clear_valid   <= 1'b0;
            clear_attack  <= '0;
        end else begin
            clear_valid  <= |full_rows;
            clear_attack <= attack_lookup;
            if (|full_rows) begin
                lines_cleared <= lines_cleared + row_count;
            end
        end
    end

    // one tetromino spans at most four rows
    a_max_four_rows: assert property (@(posedge clk) disable iff (!rst_n)
        $countones(full_rows) <= 4);

endmodule

`default_nettype wire

// ==== playfield_store.sv ====
`timescale 1ns/1ps
`default_nettype none

module playfield_store #(
    parameter int ROWS = 20,
    parameter int COLS = 10
) (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   start,
    input  logic                                   lock_valid,
    input  tetris_pkg::piece_lock_t                lock,
    input  logic [ROWS-1:0]                        full_rows,
    input  logic [ROWS-1:0]                        empty_rows,
    input  logic                                   push_valid,
    input  tetris_pkg::col_idx_t                   hole_col,
    output tetris_pkg::tile_t [ROWS-1:0][COLS-1:0] cells
);

    tetris_pkg::tile_t [ROWS-1:0][COLS-1:0] cells_next;
    tetris_pkg::tile_t [COLS-1:0]           blank_row;
    tetris_pkg::tile_t [COLS-1:0]           garbage_row;
    logic                                   lock_in_range;
    logic                                   lock_on_blank;

    always_comb begin
        for (int c = 0; c < COLS; c++) begin
            blank_row[c]   = tetris_pkg::BLANK;
            garbage_row[c] = (c == int'(hole_col)) ? tetris_pkg::BLANK : tetris_pkg::GARBAGE;
        end
    end

    // start, lock, push, then clear and collapse
    always_comb begin
        cells_next = cells;
        if (start) begin
            for (int r = 0; r < ROWS; r++) begin
                cells_next[r] = blank_row;
            end
        end else if (lock_valid) begin
            for (int k = 0; k < 4; k++) begin
                cells_next[lock.cells[k].row][lock.cells[k].col] = lock.kind;
            end
        end else if (push_valid) begin
            // whole stack moves up, new garbage row enters at the bottom
            for (int r = 0; r < ROWS - 1; r++) begin
                cells_next[r] = cells[r + 1];
            end
            cells_next[ROWS - 1] = garbage_row;
        end else begin
            for (int r = 0; r < ROWS; r++) begin
                if (full_rows[r]) begin
                    cells_next[r] = blank_row;
                end
            end
            // a row whose content drops into the empty row below is vacated
            for (int r = 0; r < ROWS - 1; r++) begin
                if (empty_rows[r + 1]) begin
                    cells_next[r] = blank_row;
                end
            end
            for (int r = 1; r < ROWS; r++) begin
                if (empty_rows[r]) begin
                    cells_next[r] = cells[r - 1];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < ROWS; r++) begin
                for (int c = 0; c < COLS; c++) begin
                    cells[r][c] <= tetris_pkg::BLANK;
                end
            end
        end else begin
            cells <= cells_next;
        end
    end

    always_comb begin
        lock_in_range = 1'b1;
        lock_on_blank = 1'b1;
        for (int k = 0; k < 4; k++) begin
            if (int'(lock.cells[k].row) >= ROWS || int'(lock.cells[k].col) >= COLS) begin
                lock_in_range = 1'b0;
            end else if (cells[lock.cells[k].row][lock.cells[k].col] != tetris_pkg::BLANK) begin
                lock_on_blank = 1'b0;
            end
        end
    end

    // index typedefs bound the geometry
    a_geometry: assert property (@(posedge clk) ROWS <= 32 && COLS <= 16);

    a_lock_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        lock_valid |-> lock_in_range);

    a_lock_on_blank: assert property (@(posedge clk) disable iff (!rst_n)
        lock_valid && !start |-> lock_on_blank);

    a_lock_no_push: assert property (@(posedge clk) disable iff (!rst_n)
        lock_valid |-> !push_valid);

endmodule

`default_nettype wire

// ==== tb_tetris_playfield.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_tetris_playfield;

    localparam int ROWS             = 20;
    localparam int COLS             = 10;
    localparam int CLK_PERIOD       = 4;
    localparam int IDLE_LIMIT       = 64;
    // locks, starts and garbage adds, each with a generous settle time
    localparam int EVENT_COUNT      = 80;
    localparam int CYCLES_PER_EVENT = 48;
    localparam int STIM_CYCLES      = EVENT_COUNT * CYCLES_PER_EVENT + 16;

    typedef tetris_pkg::tile_t [ROWS-1:0][COLS-1:0] field_t;

    logic                    clk;
    logic                    rst_n;
    logic                    start;
    logic                    lock_valid;
    tetris_pkg::piece_lock_t lock;
    logic                    garbage_valid;
    tetris_pkg::line_count_t garbage_lines;
    field_t                  playfield;
    tetris_pkg::line_count_t lines_cleared;
    logic                    attack_valid;
    tetris_pkg::line_count_t attack_lines;
    tetris_pkg::line_count_t pending_garbage;
    logic                    busy;

    field_t                  model_field;
    tetris_pkg::line_count_t model_lines;
    tetris_pkg::line_count_t model_pending;
    tetris_pkg::line_count_t model_attack;
    logic [7:0]              model_hole_lfsr;
    logic [31:0]             rand_state;
    tetris_pkg::line_count_t attack_seen;
    int                      attack_pulses = 0;
    int                      error_count = 0;
    int                      check_count = 0;
    int                      gap;
    event                    compare_ev;

    tetris_playfield #(.ROWS(ROWS), .COLS(COLS)) u_tetris_playfield (
        .clk             (clk),
        .rst_n           (rst_n),
        .start           (start),
        .lock_valid      (lock_valid),
        .lock            (lock),
        .garbage_valid   (garbage_valid),
        .garbage_lines   (garbage_lines),
        .playfield       (playfield),
        .lines_cleared   (lines_cleared),
        .attack_valid    (attack_valid),
        .attack_lines    (attack_lines),
        .pending_garbage (pending_garbage),
        .busy            (busy)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic int take_bits(input int n);
        int value;
        value = 0;
        for (int i = 0; i < n; i++) begin
            rand_state = lfsr_next(rand_state);
            value = (value << 1) | rand_state[0];
        end
        return value;
    endfunction

    function automatic tetris_pkg::tile_t random_kind();
        return tetris_pkg::tile_t'(take_bits(3) % 7 + 1);
    endfunction

    function automatic field_t blank_field();
        field_t f;
        for (int r = 0; r < ROWS; r++) begin
            for (int c = 0; c < COLS; c++) begin
                f[r][c] = tetris_pkg::BLANK;
            end
        end
        return f;
    endfunction

    // topmost occupied row of a column, ROWS when the column is empty
    function automatic int column_top(input int col);
        int top;
        top = ROWS;
        for (int r = ROWS - 1; r >= 0; r--) begin
            if (model_field[r][col] != tetris_pkg::BLANK) begin
                top = r;
            end
        end
        return top;
    endfunction

    // expected field, totals and attack after one lock has fully settled
    function automatic void model_lock(input tetris_pkg::piece_lock_t lk);
        field_t          src;
        int              full_count;
        int              w;
        logic [COLS-1:0] filled;
        src = model_field;
        for (int k = 0; k < 4; k++) begin
            src[lk.cells[k].row][lk.cells[k].col] = lk.kind;
        end
        model_field = blank_field();
        full_count = 0;
        w = ROWS - 1;
        // full rows vanish, the others drop to the bottom in order
        for (int r = ROWS - 1; r >= 0; r--) begin
            for (int c = 0; c < COLS; c++) begin
                filled[c] = (src[r][c] != tetris_pkg::BLANK);
            end
            if (&filled) begin
                full_count++;
            end else if (|filled) begin
                model_field[w] = src[r];
                w--;
            end
        end
        case (full_count)
            2:       model_attack = 10'd1;
            3:       model_attack = 10'd2;
            4:       model_attack = 10'd4;
            default: model_attack = 10'd0;
        endcase
        model_lines = model_lines + tetris_pkg::line_count_t'(full_count);
        if (full_count > 0) begin
            if (model_attack >= model_pending) begin
                model_attack  = model_attack - model_pending;
                model_pending = '0;
            end else begin
                model_pending = model_pending - model_attack;
                model_attack  = '0;
            end
        end
        while (model_pending != '0) begin
            for (int r = 0; r < ROWS - 1; r++) begin
                model_field[r] = model_field[r + 1];
            end
            for (int c = 0; c < COLS; c++) begin
                model_field[ROWS - 1][c] = (c == model_hole_lfsr % COLS) ?
                    tetris_pkg::BLANK : tetris_pkg::GARBAGE;
            end
            model_hole_lfsr = {model_hole_lfsr[6:0], model_hole_lfsr[7] ^ model_hole_lfsr[5]
                               ^ model_hole_lfsr[4] ^ model_hole_lfsr[3]};
            model_pending = model_pending - 1'b1;
        end
    endfunction

    function automatic void check_value(input string name, input int got, input int expected);
        check_count++;
        if (got != expected) begin
            error_count++;
            $display("FAILED t=%0t %s got %0d expected %0d", $time, name, got, expected);
        end
    endfunction

    always @(negedge clk) begin
        if (attack_valid) begin
            attack_pulses++;
            attack_seen = attack_lines;
        end
    end

    always begin
        @(compare_ev);
        for (int r = 0; r < ROWS; r++) begin
            for (int c = 0; c < COLS; c++) begin
                check_value($sformatf("playfield[%0d][%0d]", r, c), playfield[r][c],
                            model_field[r][c]);
            end
        end
        check_value("lines_cleared", lines_cleared, model_lines);
        check_value("pending_garbage", pending_garbage, model_pending);
        check_value("busy", busy, 0);
        check_value("attack_valid", attack_valid, 0);
        check_value("attack_valid pulses", attack_pulses, (model_attack != '0) ? 1 : 0);
        if (model_attack != '0) begin
            check_value("attack_lines", attack_seen, model_attack);
        end
        attack_pulses = 0;
        model_attack  = '0;
    end

    task automatic compare_now();
        -> compare_ev;
        @(negedge clk);
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (busy && n < IDLE_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (busy) begin
            error_count++;
            $display("busy stayed high for %0d cycles at t=%0t", IDLE_LIMIT, $time);
        end
        @(negedge clk);
    endtask

    task automatic send_lock(input tetris_pkg::piece_lock_t lk);
        lock       = lk;
        lock_valid = 1'b1;
        @(negedge clk);
        lock_valid = 1'b0;
        for (int k = 0; k < 4; k++) begin
            check_value($sformatf("playfield[%0d][%0d]", lk.cells[k].row, lk.cells[k].col),
                        playfield[lk.cells[k].row][lk.cells[k].col], lk.kind);
        end
        model_lock(lk);
        wait_idle();
        compare_now();
    endtask

    task automatic pulse_start();
        start = 1'b1;
        @(negedge clk);
        start         = 1'b0;
        model_field   = blank_field();
        model_lines   = '0;
        model_pending = '0;
        model_attack  = '0;
        compare_now();
    endtask

    task automatic add_garbage(input int lines);
        garbage_valid = 1'b1;
        garbage_lines = tetris_pkg::line_count_t'(lines);
        @(negedge clk);
        garbage_valid = 1'b0;
        model_pending = model_pending + tetris_pkg::line_count_t'(lines);
        compare_now();
    endtask

    // vertical I piece resting on top of the column
    task automatic drop_column(input int col);
        tetris_pkg::piece_lock_t lk;
        int                      top;
        top = column_top(col);
        for (int k = 0; k < 4; k++) begin
            lk.cells[k].row = tetris_pkg::row_idx_t'(top - 1 - k);
            lk.cells[k].col = tetris_pkg::col_idx_t'(col);
        end
        lk.kind = random_kind();
        send_lock(lk);
    endtask

    task automatic random_drop();
        int col;
        col = take_bits(4) % COLS;
        while (column_top(col) < 4) begin
            col = (col + 1) % COLS;
        end
        drop_column(col);
    endtask

    task automatic build_well(input int gap_col);
        for (int c = 0; c < COLS; c++) begin
            if (c != gap_col) begin
                drop_column(c);
            end
        end
    endtask

    // k cells close the bottom rows, the rest sit above the well
    task automatic fill_gap(input int gap_col, input int k);
        tetris_pkg::piece_lock_t lk;
        for (int i = 0; i < 4; i++) begin
            if (i < k) begin
                lk.cells[i].row = tetris_pkg::row_idx_t'(ROWS - 1 - i);
                lk.cells[i].col = tetris_pkg::col_idx_t'(gap_col);
            end else begin
                lk.cells[i].row = tetris_pkg::row_idx_t'(ROWS - 5);
                lk.cells[i].col = tetris_pkg::col_idx_t'((gap_col + 1 + i) % COLS);
            end
        end
        lk.kind = random_kind();
        send_lock(lk);
    endtask

    initial begin
        #(2 * STIM_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, tests did not finish", 2 * STIM_CYCLES);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        rst_n           = 1'b0;
        start           = 1'b0;
        lock_valid      = 1'b0;
        lock            = '0;
        garbage_valid   = 1'b0;
        garbage_lines   = '0;
        rand_state      = 32'he38c_9930;
        model_hole_lfsr = 8'ha5;
        model_field     = blank_field();
        model_lines     = '0;
        model_pending   = '0;
        model_attack    = '0;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        compare_now();
        pulse_start();
        // no row can fill while the last column stays open
        for (int i = 0; i < 4; i++) begin
            drop_column(take_bits(4) % (COLS - 1));
        end
        for (int k = 1; k <= 4; k++) begin
            pulse_start();
            gap = take_bits(4) % COLS;
            build_well(gap);
            fill_gap(gap, k);
        end
        // start also drops garbage that is still pending
        add_garbage(2);
        // tetris against three pending rows leaves one row of attack
        pulse_start();
        gap = take_bits(4) % COLS;
        build_well(gap);
        add_garbage(3);
        fill_gap(gap, 4);
        // double cancels one of five, four rows rise afterwards
        pulse_start();
        gap = take_bits(4) % COLS;
        build_well(gap);
        add_garbage(5);
        fill_gap(gap, 2);
        add_garbage(2);
        for (int i = 0; i < 3; i++) begin
            random_drop();
        end
        @(negedge clk);
        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tetris_pkg.sv ====
`default_nettype none

package tetris_pkg;

    // tile codes held in the locked playfield, BLANK is the cleared value
    typedef enum logic [3:0] {
        BLANK   = 4'd0,
        I       = 4'd1,
        O       = 4'd2,
        T       = 4'd3,
        S       = 4'd4,
        Z       = 4'd5,
        J       = 4'd6,
        L       = 4'd7,
        GARBAGE = 4'd8
    } tile_t;

    // row 0 is the top of the stack
    typedef logic [4:0] row_idx_t;
    typedef logic [3:0] col_idx_t;

    // line totals, pending garbage and attack amounts
    typedef logic [9:0] line_count_t;

    typedef struct packed {
        row_idx_t row;
        col_idx_t col;
    } cell_t;

    // payload of a lock strobe
    typedef struct packed {
        cell_t [3:0] cells;
        tile_t       kind;
    } piece_lock_t;

    // attack sent for 1, 2, 3 and 4 rows cleared by one lock
    localparam line_count_t ATTACK_SINGLE = 10'd0;
    localparam line_count_t ATTACK_DOUBLE = 10'd1;
    localparam line_count_t ATTACK_TRIPLE = 10'd2;
    localparam line_count_t ATTACK_TETRIS = 10'd4;

    // seed of the garbage hole LFSR
    localparam logic [7:0] GARBAGE_LFSR_SEED = 8'ha5;

endpackage

`default_nettype wire

// ==== tetris_playfield.f ====
tetris_pkg.sv
line_scanner.sv
playfield_store.sv
line_tally.sv
garbage_queue.sv
tetris_playfield.sv
tb_tetris_playfield.sv

// ==== tetris_playfield.sv ====
`timescale 1ns/1ps
`default_nettype none

module tetris_playfield #(
    parameter int ROWS = 20,
    parameter int COLS = 10
) (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   start,
    input  logic                                   lock_valid,
    input  tetris_pkg::piece_lock_t                lock,
    input  logic                                   garbage_valid,
    input  tetris_pkg::line_count_t                garbage_lines,
    output tetris_pkg::tile_t [ROWS-1:0][COLS-1:0] playfield,
    output tetris_pkg::line_count_t                lines_cleared,
    output logic                                   attack_valid,
    output tetris_pkg::line_count_t                attack_lines,
    output tetris_pkg::line_count_t                pending_garbage,
    output logic                                   busy
);

    logic [ROWS-1:0]         full_rows;
    logic [ROWS-1:0]         empty_rows;
    logic                    settled;
    logic                    clear_valid;
    tetris_pkg::line_count_t clear_attack;
    logic                    push_valid;
    tetris_pkg::col_idx_t    hole_col;

    playfield_store #(.ROWS(ROWS), .COLS(COLS)) u_playfield_store (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .lock_valid (lock_valid),
        .lock       (lock),
        .full_rows  (full_rows),
        .empty_rows (empty_rows),
        .push_valid (push_valid),
        .hole_col   (hole_col),
        .cells      (playfield)
    );

    line_scanner #(.ROWS(ROWS), .COLS(COLS)) u_line_scanner (
        .cells      (playfield),
        .full_rows  (full_rows),
        .empty_rows (empty_rows),
        .settled    (settled)
    );

    line_tally #(.ROWS(ROWS)) u_line_tally (
        .clk           (clk),
        .rst_n         (rst_n),
        .start         (start),
        .full_rows     (full_rows),
        .lines_cleared (lines_cleared),
        .clear_valid   (clear_valid),
        .clear_attack  (clear_attack)
    );

    garbage_queue #(.COLS(COLS)) u_garbage_queue (
        .clk             (clk),
        .rst_n           (rst_n),
        .start           (start),
        .garbage_valid   (garbage_valid),
        .garbage_lines   (garbage_lines),
        .clear_valid     (clear_valid),
        .clear_attack    (clear_attack),
        .lock_valid      (lock_valid),
        .settled         (settled),
        .pending_garbage (pending_garbage),
        .attack_valid    (attack_valid),
        .attack_lines    (attack_lines),
        .push_valid      (push_valid),
        .hole_col        (hole_col),
        .busy            (busy)
    );

endmodule

`default_nettype wire
